//--- verilog/fpu_settings.svh
`ifndef FPU_SETTINGS_SVH
`define FPU_SETTINGS_SVH

// binary32 field layout
`define FPU_EXP_W 8   // biased exponent bits
`define FPU_MAN_W 23  // stored fraction bits, hidden bit not included

// exponent bias for binary32
`define FPU_BIAS 127

// bits kept below the lsb while aligning for add/sub
// guard, round, then one sticky bit
`define FPU_GRS_W 3

// fraction of the quiet NaN the unit generates itself
// only the top fraction bit is set
`define FPU_QNAN_MAN 23'h40_0000

`endif

//--- verilog/fpu_pkg.sv
`default_nettype none

`include "fpu_settings.svh"

package fpu_pkg;

  // one binary32 word: sign, exponent, fraction
  typedef logic [`FPU_EXP_W+`FPU_MAN_W:0] fp32_t;

  typedef logic [`FPU_EXP_W-1:0] fpu_exp_t; // biased exponent
  typedef logic [`FPU_MAN_W:0]   fpu_man_t; // hidden bit made explicit

  // supported operations
  typedef enum logic [1:0] {
    op_add = 2'd0,
    op_sub = 2'd1,
    op_mul = 2'd2
  } fpu_op_t;

  // number of leading zeros in a 32 bit word, 32 when it is all zero
  function automatic logic [5:0] lzc(input logic [31:0] val);
    logic [5:0] cnt;
    logic       found;
    cnt   = 6'd32;
    found = 1'b0;
    for (int i = 31; i >= 0; i--) begin
      if (val[i] && !found) begin // first one seen from the top
        cnt   = 6'(31 - i);
        found = 1'b1;
      end
    end
    return cnt;
  endfunction

endpackage

`default_nettype wire

//--- verilog/fpu_unpack.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_settings.svh"

module fpu_unpack (
  input  fpu_pkg::fp32_t    operand,
  output logic              sign,
  output fpu_pkg::fpu_exp_t exp,
  output fpu_pkg::fpu_man_t man,
  output logic              is_nan,
  output logic              is_inf,
  output logic              is_zero,
  output logic              is_sub
);
  import fpu_pkg::*;

  fpu_exp_t              exp_fld;
  logic [`FPU_MAN_W-1:0] man_fld;
  logic                  exp_max; // all ones, inf or nan
  logic                  exp_min; // all zeros, zero or subnormal
  logic                  man_nz;

  assign sign    = operand[`FPU_EXP_W+`FPU_MAN_W];
  assign exp_fld = operand[`FPU_EXP_W+`FPU_MAN_W-1 -: `FPU_EXP_W];
  assign man_fld = operand[`FPU_MAN_W-1:0];

  assign exp_max = &exp_fld;
  assign exp_min = ~|exp_fld;
  assign man_nz  = |man_fld;

  assign is_nan  = exp_max &  man_nz;
  assign is_inf  = exp_max & ~man_nz;
  assign is_zero = exp_min & ~man_nz;
  assign is_sub  = exp_min &  man_nz;

  // subnormals live at the minimum exponent with a zero hidden bit
  assign exp = is_sub ? fpu_exp_t'(1) : exp_fld;
  assign man = {~exp_min, man_fld}; // hidden bit clear for zero too

endmodule

`default_nettype wire

//--- verilog/fpu_addsub.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_settings.svh"

module fpu_addsub (
  input  fpu_pkg::fpu_op_t  op,
  input  logic              a_sign,
  input  logic              b_sign,
  input  fpu_pkg::fpu_exp_t a_exp,
  input  fpu_pkg::fpu_exp_t b_exp,
  input  fpu_pkg::fpu_man_t a_man,
  input  fpu_pkg::fpu_man_t b_man,
  input  logic              a_nan,
  input  logic              a_inf,
  input  logic              b_nan,
  input  logic              b_inf,
  output fpu_pkg::fp32_t    res
);
  import fpu_pkg::*;

  localparam int MW     = `FPU_MAN_W + 1; // mantissa with hidden bit
  localparam int GW     = `FPU_GRS_W;
  localparam int HI     = MW + 1;         // two's complement sign, carry sits right below
  localparam int SH_MAX = MW + GW - 1;    // any larger shift only feeds the sticky bit

  logic                   b_eff_sign; // b sign after folding in the subtraction
  logic                   swap;       // b has the larger exponent
  fpu_exp_t               exp_big;
  fpu_exp_t               diff;
  logic [4:0]             dsh;
  fpu_man_t               man_big;
  fpu_man_t               man_small;
  logic [MW+SH_MAX-1:0]   win;        // small mantissa after the alignment shift
  logic [HI:-GW]          big_al;
  logic [HI:-GW]          small_al;
  logic [HI:-GW]          a_al;
  logic [HI:-GW]          b_al;
  logic [HI:-GW]          sum;
  logic [HI:-GW]          m_abs;
  logic                   carry;
  logic [HI:-GW]          m_nc;       // carry folded back in
  fpu_exp_t               e_pre;
  logic [5:0]             zcount;
  fpu_exp_t               shift_lim;
  logic [5:0]             nshift;
  logic [HI:-GW]          m_norm;
  fpu_exp_t               e_norm;
  logic [GW-1:0]          grs;
  logic                   round_up;
  logic [HI:0]            m_rnd;
  logic                   rnd_carry;
  logic [HI:0]            m_fin;
  fpu_exp_t               e_fin;
  fpu_exp_t               e_field;
  logic                   special;

  assign b_eff_sign = b_sign ^ (op == op_sub);

  // alignment, the smaller operand moves right
  assign swap      = b_exp > a_exp;
  assign exp_big   = swap ? b_exp : a_exp;
  assign diff      = swap ? (b_exp - a_exp) : (a_exp - b_exp);
  assign man_big   = swap ? b_man : a_man;
  assign man_small = swap ? a_man : b_man;
  assign dsh       = (diff > fpu_exp_t'(SH_MAX)) ? 5'(SH_MAX) : diff[4:0];
  assign win       = {man_small, {SH_MAX{1'b0}}} >> dsh;

  assign big_al   = {2'b00, man_big, {GW{1'b0}}};
  assign small_al = {2'b00, win[MW+SH_MAX-1 -: MW+GW-1], |win[SH_MAX-GW:0]}; // or in sticky
  assign a_al     = swap ? small_al : big_al;
  assign b_al     = swap ? big_al : small_al;

  // signed add, both operands negated by their own sign
  assign sum   = (a_sign ? -a_al : a_al) + (b_eff_sign ? -b_al : b_al);
  assign m_abs = sum[HI] ? -sum : sum;

  // carry out of the hidden bit, shift right but keep the lost bit sticky
  assign carry = m_abs[MW];
  assign m_nc  = carry ? {1'b0, m_abs[HI:-GW+2], |m_abs[-GW+1:-GW]} : m_abs;
  assign e_pre = exp_big + fpu_exp_t'(carry);

  // leading zeros counted from the hidden bit position
  assign zcount    = lzc(32'(m_nc)) - 6'(32 - MW - GW);
  assign shift_lim = (e_pre == '0) ? '0 : e_pre - fpu_exp_t'(1); // stop at exponent 1
  assign nshift    = ({2'b00, zcount} < shift_lim) ? zcount : shift_lim[5:0];
  assign m_norm    = m_nc << nshift;
  assign e_norm    = e_pre - {2'b00, nshift};

  // round to nearest, ties to even
  assign grs      = m_norm[-1:-GW];
  assign round_up = grs[GW-1] & ((|grs[GW-2:0]) | m_norm[0]);
  assign m_rnd    = m_norm[HI:0] + {{HI{1'b0}}, round_up};

  assign rnd_carry = m_rnd[MW];
  assign m_fin     = rnd_carry ? (m_rnd >> 1) : m_rnd;
  assign e_fin     = e_norm + fpu_exp_t'(rnd_carry);
  assign e_field   = m_fin[MW-1] ? e_fin : '0; // no hidden bit means subnormal encoding

  assign special = a_nan | b_nan | a_inf | b_inf;

  always_comb begin
    if (a_nan) begin
      res = {a_sign, a_exp, a_man[`FPU_MAN_W-1:0]};                  // a wins over b
    end else if (b_nan) begin
      res = {b_sign, b_exp, b_man[`FPU_MAN_W-1:0]};
    end else if (a_inf && b_inf && (a_sign != b_eff_sign)) begin
      res = {1'b0, {`FPU_EXP_W{1'b1}}, `FPU_QNAN_MAN};               // inf - inf
    end else if (a_inf) begin
      res = {a_sign, {`FPU_EXP_W{1'b1}}, {`FPU_MAN_W{1'b0}}};
    end else if (b_inf) begin
      res = {b_eff_sign, {`FPU_EXP_W{1'b1}}, {`FPU_MAN_W{1'b0}}};    // sign flips for sub
    end else if (m_fin == '0) begin
      res = '0;                                                       // exact zero is +0
    end else begin
      res = {sum[HI], e_field, m_fin[`FPU_MAN_W-1:0]};
    end
  end

  // exponent above the minimum means normalization reached the hidden bit
  always_comb begin
    if (!special && (m_fin != '0) && (e_norm > fpu_exp_t'(1))) begin
      norm_hidden_a: assert final (m_norm[MW-1])
        else $error("addsub result left unnormalized above minimum exponent");
    end
  end

endmodule

`default_nettype wire

//--- verilog/fpu_mul.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_settings.svh"

module fpu_mul (
  input  logic              a_sign,
  input  logic              b_sign,
  input  fpu_pkg::fpu_exp_t a_exp,
  input  fpu_pkg::fpu_exp_t b_exp,
  input  fpu_pkg::fpu_man_t a_man,
  input  fpu_pkg::fpu_man_t b_man,
  input  logic              a_nan,
  input  logic              a_inf,
  input  logic              a_zero,
  input  logic              b_nan,
  input  logic              b_inf,
  input  logic              b_zero,
  output fpu_pkg::fp32_t    res
);
  import fpu_pkg::*;

  localparam int MW = `FPU_MAN_W + 1;

  logic                  sign;
  logic [2*MW-1:0]       prod;   // 1.x * 1.x gives 01.x or 1x.x
  fpu_exp_t              e_sum;
  logic [2*MW-1:0]       p_norm; // top bit is the hidden bit
  fpu_exp_t              e_norm;
  logic                  round_up;
  logic [MW:0]           p_rnd;
  logic                  rnd_carry;
  logic [`FPU_MAN_W-1:0] m_fin;
  fpu_exp_t              e_fin;

  assign sign  = a_sign ^ b_sign;
  assign prod  = a_man * b_man;
  assign e_sum = a_exp - fpu_exp_t'(`FPU_BIAS) + b_exp; // no range check, wraps

  assign p_norm = prod[2*MW-1] ? prod : (prod << 1);
  assign e_norm = e_sum + fpu_exp_t'(prod[2*MW-1]);

  // guard is bit MW-1, everything below is sticky
  assign round_up  = p_norm[MW-1] & ((|p_norm[MW-2:0]) | p_norm[MW]);
  assign p_rnd     = {1'b0, p_norm[2*MW-1:MW]} + {{MW{1'b0}}, round_up};
  assign rnd_carry = p_rnd[MW];
  assign m_fin     = rnd_carry ? p_rnd[MW-1:1] : p_rnd[MW-2:0];
  assign e_fin     = e_norm + fpu_exp_t'(rnd_carry);

  always_comb begin
    if (a_nan) begin
      res = {a_sign, a_exp, a_man[`FPU_MAN_W-1:0]};
    end else if (b_nan) begin
      res = {b_sign, b_exp, b_man[`FPU_MAN_W-1:0]};
    end else if ((a_zero && b_inf) || (a_inf && b_zero)) begin
      res = {1'b0, {`FPU_EXP_W{1'b1}}, `FPU_QNAN_MAN}; // 0 * inf
    end else if (a_inf || b_inf) begin
      res = {sign, {`FPU_EXP_W{1'b1}}, {`FPU_MAN_W{1'b0}}};
    end else if (a_zero || b_zero) begin
      res = {sign, {`FPU_EXP_W{1'b0}}, {`FPU_MAN_W{1'b0}}};
    end else begin
      res = {sign, e_fin, m_fin};
    end
  end

  // normal operands put the hidden bit at MW-1 or one above it after rounding
  always_comb begin
    if (a_man[MW-1] && b_man[MW-1]) begin
      rnd_once_a: assert final (p_rnd[MW] || p_rnd[MW-1])
        else $error("mul mantissa needs a second renormalization");
    end
  end

endmodule

`default_nettype wire

//--- verilog/fpu_result_reg.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_result_reg (
  input  logic             clk,
  input  logic             rst,
  input  logic             in_valid,
  input  fpu_pkg::fpu_op_t op,
  input  fpu_pkg::fp32_t   addsub_res,
  input  fpu_pkg::fp32_t   mul_res,
  output fpu_pkg::fp32_t   result,
  output logic             out_valid
);
  import fpu_pkg::*;

  fp32_t sel_res;

  // add and sub share one datapath
  assign sel_res = (op == op_mul) ? mul_res : addsub_res;

  always_ff @(posedge clk) begin
    if (rst) begin
      result    <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid; // fixed one cycle latency
      if (in_valid) begin
        result <= sel_res;   // holds while idle
      end
    end
  end

  // only the three defined opcodes may be issued
  op_defined_a: assert property (
    @(posedge clk) disable iff (rst)
    in_valid |-> (op inside {op_add, op_sub, op_mul})
  ) else $error("undefined opcode issued with in_valid");

endmodule

`default_nettype wire

//--- verilog/fpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_top (
  input  logic             clk,
  input  logic             rst,
  input  logic             in_valid,
  input  fpu_pkg::fp32_t   a,
  input  fpu_pkg::fp32_t   b,
  input  fpu_pkg::fpu_op_t op,
  output fpu_pkg::fp32_t   result,
  output logic             out_valid
);
  import fpu_pkg::*;

  // unpacked operand a
  logic     a_sign;
  fpu_exp_t a_exp;
  fpu_man_t a_man;
  logic     a_nan;
  logic     a_inf;
  logic     a_zero;
  logic     a_sub;

  // unpacked operand b
  logic     b_sign;
  fpu_exp_t b_exp;
  fpu_man_t b_man;
  logic     b_nan;
  logic     b_inf;
  logic     b_zero;
  logic     b_sub;

  fp32_t    addsub_res;
  fp32_t    mul_res;

  fpu_unpack u_unpack_a (
    .operand (a),
    .sign    (a_sign),
    .exp     (a_exp),
    .man     (a_man),
    .is_nan  (a_nan),
    .is_inf  (a_inf),
    .is_zero (a_zero),
    .is_sub  (a_sub)
  );

  fpu_unpack u_unpack_b (
    .operand (b),
    .sign    (b_sign),
    .exp     (b_exp),
    .man     (b_man),
    .is_nan  (b_nan),
    .is_inf  (b_inf),
    .is_zero (b_zero),
    .is_sub  (b_sub)
  );

  fpu_addsub u_addsub (
    .op     (op),
    .a_sign (a_sign),
    .b_sign (b_sign),
    .a_exp  (a_exp),
    .b_exp  (b_exp),
    .a_man  (a_man),
    .b_man  (b_man),
    .a_nan  (a_nan),
    .a_inf  (a_inf),
    .b_nan  (b_nan),
    .b_inf  (b_inf),
    .res    (addsub_res)
  );

  fpu_mul u_mul (
    .a_sign (a_sign),
    .b_sign (b_sign),
    .a_exp  (a_exp),
    .b_exp  (b_exp),
    .a_man  (a_man),
    .b_man  (b_man),
    .a_nan  (a_nan),
    .a_inf  (a_inf),
    .a_zero (a_zero | a_sub), // subnormal mul inputs are never driven
    .b_nan  (b_nan),
    .b_inf  (b_inf),
    .b_zero (b_zero | b_sub),
    .res    (mul_res)
  );

  fpu_result_reg u_result (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .op         (op),
    .addsub_res (addsub_res),
    .mul_res    (mul_res),
    .result     (result),
    .out_valid  (out_valid)
  );

endmodule

`default_nettype wire

//--- bench/fpu_ref_model.svh
`ifndef FPU_REF_MODEL_SVH
`define FPU_REF_MODEL_SVH

// finite operands become exact integers, value = mag * 2^-k
localparam fpu_pkg::fp32_t CANON_NAN = 32'h7fc0_0000;

function automatic logic nan_word(input fpu_pkg::fp32_t x);
  return (&x[30:23]) && (|x[22:0]);
endfunction

function automatic logic inf_word(input fpu_pkg::fp32_t x);
  return (&x[30:23]) && !(|x[22:0]);
endfunction

// significand with the hidden bit, clear for zero and subnormals
function automatic logic [23:0] sig_of(input fpu_pkg::fp32_t x);
  return {x[30:23] != 8'd0, x[22:0]};
endfunction

// biased exponent of the significand, subnormals sit at 1
function automatic int exp_of(input fpu_pkg::fp32_t x);
  return (x[30:23] == 8'd0) ? 1 : int'(x[30:23]);
endfunction

// highest set bit or -1 for zero
function automatic int msb_pos(input logic [319:0] mag);
  int pos;
  pos = -1;
  for (int i = 319; i >= 0; i--) begin
    if (pos < 0 && mag[i]) begin
      pos = i;
    end
  end
  return pos;
endfunction

// exponent and fraction fields of mag * 2^-k, nearest even, gradual underflow
function automatic logic [30:0] round_fields(input logic [319:0] mag, input int k);
  int           s;
  int           e;
  logic [319:0] keep;
  logic         guard;
  logic         sticky;
  s = msb_pos(mag) - 23;                  // keep 24 significant bits
  if (s < k - 149) s = k - 149;           // not below the subnormal lsb
  keep   = mag >> s;
  guard  = 1'b0;
  sticky = 1'b0;
  if (s > 0) guard = mag[s-1];
  if (s > 1) sticky = (mag & ((320'd1 << (s - 1)) - 320'd1)) != '0;
  if (guard && (sticky || keep[0])) keep = keep + 320'd1;
  if (keep[24]) begin                     // rounded up to the next power of two
    keep = keep >> 1;
    s++;
  end
  e = s - k + 150;
  if (!keep[23]) e = 0;                   // subnormal encoding
  return {8'(e), keep[22:0]};
endfunction

function automatic fpu_pkg::fp32_t addsub_expected(input fpu_pkg::fpu_op_t sel,
                                                   input fpu_pkg::fp32_t x,
                                                   input fpu_pkg::fp32_t y);
  logic         ys;                       // sign of y as the adder sees it
  logic         rs;
  logic [319:0] mx;
  logic [319:0] my;
  logic [319:0] mag;
  ys = y[31] ^ (sel == fpu_pkg::op_sub);
  if (nan_word(x)) return x;              // a wins over b
  if (nan_word(y)) return y;
  if (inf_word(x) && inf_word(y) && (x[31] != ys)) return CANON_NAN;
  if (inf_word(x)) return x;
  if (inf_word(y)) return {ys, y[30:0]};
  mx = 320'(sig_of(x)) << (exp_of(x) - 1); // units of 2^-149
  my = 320'(sig_of(y)) << (exp_of(y) - 1);
  if (x[31] == ys) begin
    mag = mx + my;
    rs  = x[31];
  end else if (mx >= my) begin
    mag = mx - my;
    rs  = x[31];
  end else begin
    mag = my - mx;
    rs  = ys;
  end
  if (mag == '0) return '0;               // exact zero is always +0
  return {rs, round_fields(mag, 149)};
endfunction

function automatic fpu_pkg::fp32_t mul_expected(input fpu_pkg::fp32_t x,
                                                input fpu_pkg::fp32_t y);
  logic         rs;
  logic [319:0] prod;
  rs = x[31] ^ y[31];
  if (nan_word(x)) return x;
  if (nan_word(y)) return y;
  if ((x[30:0] == '0 && inf_word(y)) || (inf_word(x) && y[30:0] == '0)) return CANON_NAN;
  if (inf_word(x) || inf_word(y)) return {rs, 8'hff, 23'd0};
  if (x[30:0] == '0 || y[30:0] == '0) return {rs, 31'd0};
  prod = 320'(sig_of(x)) * 320'(sig_of(y));
  return {rs, round_fields(prod, 300 - exp_of(x) - exp_of(y))}; // 2^(ex+ey-300)
endfunction

function automatic fpu_pkg::fp32_t expected_result(input fpu_pkg::fpu_op_t sel,
                                                   input fpu_pkg::fp32_t x,
                                                   input fpu_pkg::fp32_t y);
  return (sel == fpu_pkg::op_mul) ? mul_expected(x, y) : addsub_expected(sel, x, y);
endfunction

`endif

//--- bench/fpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_tb;
  import fpu_pkg::*;

  `include "fpu_ref_model.svh"

  localparam int NUM_OPS       = 20000;
  localparam int MAX_CYCLES    = 4 * NUM_OPS; // in_valid is high about 3 cycles in 4
  localparam int DRAIN_TIMEOUT = 50;

  logic    clk;
  logic    rst;
  logic    in_valid;
  fp32_t   a;
  fp32_t   b;
  fpu_op_t op;
  fp32_t   result;
  logic    out_valid;

  fp32_t   exp_q[$];    // model results in issue order
  logic    last_valid;  // in_valid seen at the last rising edge
  fp32_t   last_result; // result must hold this while idle
  int      issued;
  int      cycles;
  int      waited;

  fpu_top i_dut (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .a         (a),
    .b         (b),
    .op        (op),
    .result    (result),
    .out_valid (out_valid)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_result(input fp32_t got, input fp32_t want);
    if (got !== want) begin
      abort_run($sformatf("** Error at %0t: result %h, expected %h", $time, got, want));
    end
  endtask

  task automatic check_valid(input logic got, input logic want);
    if (got !== want) begin
      abort_run($sformatf("** Error at %0t: out_valid %b, expected %b", $time, got, want));
    end
  endtask

  function automatic fp32_t rand_normal(input int lo, input int hi);
    return {1'($urandom), 8'($urandom_range(hi, lo)), 23'($urandom)};
  endfunction

  // nan, signed inf, signed zero or a mid range normal
  function automatic fp32_t special_operand();
    logic s;
    s = 1'($urandom);
    case ($urandom_range(5, 0))
      0:       return {s, 8'hff, 23'($urandom) | 23'd1}; // quiet or signalling
      1:       return {s, 8'hff, 23'd0};
      2:       return {s, 31'd0};
      default: return rand_normal(150, 100);
    endcase
  endfunction

  task automatic pick_operands(output fpu_op_t sel, output fp32_t x, output fp32_t y);
    int kind;
    int ex;
    int lo;
    int hi;
    int frac;
    sel  = fpu_op_t'($urandom_range(2, 0));
    kind = $urandom_range(7, 0);
    if (kind == 0) begin
      x = special_operand();
      y = special_operand();
    end else if (sel == op_mul) begin
      ex = $urandom_range(254, 1);
      lo = (ex < 128) ? 128 - ex : 1;   // exponent sum stays in the normal range
      hi = (ex > 125) ? 379 - ex : 254;
      x  = rand_normal(ex, ex);
      y  = rand_normal(lo, hi);
      if (kind == 1) begin              // short mantissas make ties common
        x[9:0] = '0;
        y[9:0] = '0;
      end else if (kind == 2) begin
        // 1+d*2^-23 times 2-2d*2^-23 lands just below 2 and rounds up to it
        frac    = $urandom_range(1024, 1);
        x[22:0] = 23'(frac);
        y[22:0] = 23'((1 << 23) - 2 * frac);
      end
    end else if (kind == 1) begin       // near equal magnitudes, massive cancellation
      x        = rand_normal(252, 1);
      y        = x;
      y[22:0]  = x[22:0] ^ 23'($urandom >> $urandom_range(31, 9));
      y[31]    = x[31] ^ (sel == op_add);
    end else if (kind == 2) begin       // subnormal operands and results
      x = rand_normal(2, 1);
      y = rand_normal(2, 1);
      if ($urandom_range(1, 0) == 1) x[30:23] = 8'd0;
      if ($urandom_range(1, 0) == 1) y[30:23] = 8'd0;
    end else begin
      ex = $urandom_range(252, 1);      // no carry into the inf exponent
      lo = (ex > 29) ? ex - 28 : 1;
      hi = (ex < 224) ? ex + 28 : 252;
      x  = rand_normal(ex, ex);
      y  = rand_normal(hi, lo);
    end
  endtask

  task automatic check_outputs();
    check_valid(out_valid, last_valid);
    if (last_valid) begin
      last_result = exp_q.pop_front();
    end
    check_result(result, last_result);
  endtask

  task automatic drive_next();
    fpu_op_t sel;
    fp32_t   x;
    fp32_t   y;
    if ($urandom_range(3, 0) != 0) begin
      pick_operands(sel, x, y);
      op       = sel;
      a        = x;
      b        = y;
      in_valid = 1'b1;
      exp_q.push_back(expected_result(sel, x, y));
      issued++;
    end else begin
      in_valid = 1'b0;
      a        = $urandom;              // garbage operands must not reach result
      b        = $urandom;
    end
    last_valid = in_valid;
  endtask

  initial begin
    void'($urandom(32'h1deb));
    rst         = 1'b1;
    in_valid    = 1'b0;
    a           = '0;
    b           = '0;
    op          = op_add;
    last_valid  = 1'b0;
    last_result = '0;
    issued      = 0;
    cycles      = 0;
    waited      = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    check_outputs();                    // reset values
    rst = 1'b0;
    while (issued < NUM_OPS) begin
      @(negedge clk);
      check_outputs();
      drive_next();
      cycles++;
      if (cycles > MAX_CYCLES) abort_run("stimulus did not finish within the cycle budget");
    end
    while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
      @(negedge clk);
      check_outputs();
      in_valid   = 1'b0;
      last_valid = 1'b0;
      waited++;
    end
    if (exp_q.size() == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      abort_run($sformatf("%0d results never came out of the DUT", exp_q.size()));
    end
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+verilog
+incdir+bench
verilog/fpu_pkg.sv
verilog/fpu_unpack.sv
verilog/fpu_addsub.sv
verilog/fpu_mul.sv
verilog/fpu_result_reg.sv
verilog/fpu_top.sv
bench/fpu_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the fpu testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module fpu_tb -Mdir obj_dir -f compile.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vfpu_tb
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit 1
fi

exit 0
